// File: logic/cpuTypesPkg.sv
// CPU word and datapath types
`default_nettype none

package cpuTypesPkg;

  // data word and byte address
  typedef logic [31:0] wordT;
  typedef logic [31:0] addrT;

  // hit statistic lands here at the end of a flush
  localparam addrT HIT_COUNT_ADDR = 32'h00003100;

  // datapath to cache, held as levels until dhit
  typedef struct packed {
    logic memREN;
    logic memWEN;
    logic halt;
    addrT memAddr;
    wordT memStore;
  } dpReqT;

  // cache to datapath
  typedef struct packed {
    logic dhit;
    wordT memLoad;
    logic flushed;
  } dpRespT;

endpackage

`default_nettype wire

// File: logic/cacheTypesPkg.sv
// Data cache geometry and bus types
`default_nettype none

package cacheTypesPkg;

  // two-way set associative, two-word blocks
  localparam int NUM_SETS = 8;
  localparam int NUM_WAYS = 2;
  localparam int BLOCK_WORDS = 2;
  localparam int NUM_FRAMES = NUM_SETS * NUM_WAYS;

  // address field widths
  localparam int INDEX_BITS = $clog2(NUM_SETS);
  localparam int OFF_BITS = $clog2(BLOCK_WORDS);
  localparam int TAG_BITS = 32 - INDEX_BITS - OFF_BITS - 2;

  typedef logic [TAG_BITS-1:0] tagT;
  typedef logic [INDEX_BITS-1:0] indexT;
  typedef logic [OFF_BITS-1:0] blockOffT;
  // flush walk order is set first, then way in the low bit
  typedef logic [$clog2(NUM_FRAMES)-1:0] frameNumT;

  // byte address split
  typedef struct packed {
    tagT tag;
    indexT index;
    blockOffT blockOff;
    logic [1:0] byteOff;
  } dcAddrT;

  // one way of one set
  typedef struct packed {
    logic valid;
    logic dirty;
    tagT tag;
    cpuTypesPkg::wordT [BLOCK_WORDS-1:0] data;
  } dcFrameT;

  // cache to memory
  typedef struct packed {
    logic REN;
    logic WEN;
    cpuTypesPkg::addrT addr;
    cpuTypesPkg::wordT store;
  } memReqT;

  // memory to cache, dWait high while the access is busy
  typedef struct packed {
    logic dWait;
    cpuTypesPkg::wordT load;
  } memRespT;

  // control sequencer states
  typedef enum logic [2:0] {
    IDLE,
    WRITEBACK0,
    WRITEBACK1,
    FILL0,
    FILL1,
    FLUSH,
    COUNT,
    FLUSHED
  } dcStateT;

endpackage

`default_nettype wire

// File: logic/flexCounter.sv
// Up/down counter
`timescale 1ns/1ps
`default_nettype none

module flexCounter #(
  parameter int BITS = 4
) (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            countUp,
  input  logic            countDown,
  output logic [BITS-1:0] count
);

  logic [BITS-1:0] nextCount;

  // both strobes together cancel out
  always_comb begin
    nextCount = count;
    if (countUp && !countDown) begin
      nextCount = count + 1'b1;
    end else if (countDown && !countUp) begin
      nextCount = count - 1'b1;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else begin
      count <= nextCount;
    end
  end

endmodule

`default_nettype wire

// File: logic/dcacheControl.sv
// Data cache control FSM
`timescale 1ns/1ps
`default_nettype none

module dcacheControl (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    dirty,
  input  logic                    anyDirty,
  input  logic                    dhit,
  input  logic                    memWait,
  input  logic                    memREN,
  input  logic                    memWEN,
  input  logic                    halt,
  output logic                    cacheREN,
  output logic                    cacheWEN,
  output logic                    flushStep,
  output logic                    hitUp,
  output logic                    hitDown,
  output logic                    countOut,
  output cacheTypesPkg::blockOffT blockOff,
  output logic                    invalidate,
  output logic                    flushing,
  output logic                    flushed
);
  import cacheTypesPkg::*;

  dcStateT state, nextState;
  // set once halt is taken, the writeback states then serve the flush
  logic flushMode;
  logic request;

  assign request = memREN | memWEN;
  assign flushing = flushMode;
  assign flushed = (state == FLUSHED);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      flushMode <= 1'b0;
    end else begin
      state <= nextState;
      if (nextState == FLUSH) begin
        flushMode <= 1'b1;
      end
    end
  end

  always_comb begin
    nextState = state;
    cacheREN = 1'b0;
    cacheWEN = 1'b0;
    flushStep = 1'b0;
    hitUp = 1'b0;
    hitDown = 1'b0;
    countOut = 1'b0;
    blockOff = '0;
    invalidate = 1'b0;
    case (state)
      IDLE: begin
        if (halt) begin
          nextState = FLUSH;
        end else if (request) begin
          if (dhit) begin
            // answered this cycle
            hitUp = 1'b1;
          end else if (dirty) begin
            nextState = WRITEBACK0;
          end else begin
            // clean victim, fill starts now
            nextState = FILL0;
            hitDown = 1'b1;
          end
        end
      end
      WRITEBACK0: begin
        cacheWEN = 1'b1;
        if (!memWait) begin
          nextState = WRITEBACK1;
        end
      end
      WRITEBACK1: begin
        cacheWEN = 1'b1;
        blockOff = 1'b1;
        if (!memWait) begin
          if (flushMode) begin
            // frame is clean in memory now, drop it and move on
            invalidate = 1'b1;
            flushStep = 1'b1;
            nextState = FLUSH;
          end else begin
            hitDown = 1'b1;
            nextState = FILL0;
          end
        end
      end
      FILL0: begin
        cacheREN = 1'b1;
        if (!memWait) begin
          nextState = FILL1;
        end
      end
      FILL1: begin
        cacheREN = 1'b1;
        blockOff = 1'b1;
        // second word completes the frame, request hits next cycle
        if (!memWait) begin
          nextState = IDLE;
        end
      end
      FLUSH: begin
        // walk frames until nothing dirty is left
        if (!anyDirty) begin
          nextState = COUNT;
        end else if (dirty) begin
          nextState = WRITEBACK0;
        end else begin
          flushStep = 1'b1;
        end
      end
      COUNT: begin
        cacheWEN = 1'b1;
        countOut = 1'b1;
        if (!memWait) begin
          nextState = FLUSHED;
        end
      end
      FLUSHED: begin
        // parked until reset
        nextState = FLUSHED;
      end
      default: begin
        nextState = IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/dcache.sv
// Data cache storage and datapath
`timescale 1ns/1ps
`default_nettype none

module dcache (
  input  logic                    CLK,
  input  logic                    nRST,
  input  cpuTypesPkg::dpReqT      dpReq,
  output logic                    dhit,
  output cpuTypesPkg::wordT       memLoad,
  input  cacheTypesPkg::memRespT  memResp,
  output cpuTypesPkg::addrT       memAddr,
  output cpuTypesPkg::wordT       memStore,
  output logic                    dirty,
  output logic                    anyDirty,
  input  cacheTypesPkg::blockOffT blockOff,
  input  logic                    flushing,
  input  logic                    invalidate,
  input  logic                    countOut,
  input  cacheTypesPkg::frameNumT frameNum,
  input  cpuTypesPkg::wordT       hitCount,
  input  logic                    memREN
);
  import cpuTypesPkg::*;
  import cacheTypesPkg::*;

  // frame array and per-set lru way
  dcFrameT frames [NUM_SETS][NUM_WAYS];
  logic lru [NUM_SETS];

  dcAddrT reqAddr;
  indexT idx;
  logic hit0, hit1;
  logic hitWay;
  logic waySel;
  logic request;
  logic fillDone;
  addrT fillAddr, wbAddr;

  assign reqAddr = dcAddrT'(dpReq.memAddr);
  assign request = dpReq.memREN | dpReq.memWEN;

  // flush walks frames, otherwise the request picks the set
  assign idx = flushing ? frameNum[$bits(frameNumT)-1:1] : reqAddr.index;

  // tag compare on both ways
  assign hit0 = frames[idx][0].valid && (frames[idx][0].tag == reqAddr.tag);
  assign hit1 = frames[idx][1].valid && (frames[idx][1].tag == reqAddr.tag);
  assign hitWay = hit1;
  assign dhit = request && !flushing && (hit0 || hit1);

  // hit way, else lru victim, else flush frame
  always_comb begin
    if (flushing) begin
      waySel = frameNum[0];
    end else if (hit0 || hit1) begin
      waySel = hitWay;
    end else begin
      waySel = lru[idx];
    end
  end

  // victim status for the controller
  assign dirty = frames[idx][waySel].valid && frames[idx][waySel].dirty;

  always_comb begin
    anyDirty = 1'b0;
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        anyDirty = anyDirty | (frames[s][w].valid & frames[s][w].dirty);
      end
    end
  end

  // load path
  assign memLoad = frames[idx][hitWay].data[reqAddr.blockOff];

  // memory side addressing
  assign fillAddr = {reqAddr.tag, reqAddr.index, blockOff, 2'b00};
  assign wbAddr = {frames[idx][waySel].tag, idx, blockOff, 2'b00};

  always_comb begin
    if (countOut) begin
      memAddr = HIT_COUNT_ADDR;
    end else if (memREN) begin
      memAddr = fillAddr;
    end else begin
      memAddr = wbAddr;
    end
  end

  assign memStore = countOut ? hitCount : frames[idx][waySel].data[blockOff];

  // a fill word lands on the cycle memory drops wait
  assign fillDone = memREN && !memResp.dWait && !flushing;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      frames <= '{default: '0};
      lru <= '{default: 1'b0};
    end else begin
      if (dhit) begin
        // other way becomes the victim
        lru[idx] <= ~hitWay;
        if (dpReq.memWEN) begin
          frames[idx][hitWay].data[reqAddr.blockOff] <= dpReq.memStore;
          frames[idx][hitWay].dirty <= 1'b1;
        end
      end else if (fillDone) begin
        frames[idx][waySel].data[blockOff] <= memResp.load;
        frames[idx][waySel].tag <= reqAddr.tag;
        frames[idx][waySel].dirty <= 1'b0;
        // first word clears valid so the half-filled frame cannot hit
        frames[idx][waySel].valid <= (blockOff == blockOffT'(BLOCK_WORDS - 1));
      end
      if (invalidate) begin
        frames[idx][waySel].valid <= 1'b0;
        frames[idx][waySel].dirty <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/dataCacheUnit.sv
// Data cache top level
`timescale 1ns/1ps
`default_nettype none

module dataCacheUnit (
  input  logic                   CLK,
  input  logic                   nRST,
  input  cpuTypesPkg::dpReqT     dpReq,
  output cpuTypesPkg::dpRespT    dpResp,
  output cacheTypesPkg::memReqT  memReq,
  input  cacheTypesPkg::memRespT memResp
);
  import cpuTypesPkg::*;
  import cacheTypesPkg::*;

  // control strobes
  logic dirty, anyDirty;
  logic flushStep, hitUp, hitDown, countOut;
  logic invalidate, flushing;
  blockOffT blockOff;

  // counter values
  wordT hitCount;
  frameNumT frameNum;

  dcache cache (
    .CLK        (CLK),
    .nRST       (nRST),
    .dpReq      (dpReq),
    .dhit       (dpResp.dhit),
    .memLoad    (dpResp.memLoad),
    .memResp    (memResp),
    .memAddr    (memReq.addr),
    .memStore   (memReq.store),
    .dirty      (dirty),
    .anyDirty   (anyDirty),
    .blockOff   (blockOff),
    .flushing   (flushing),
    .invalidate (invalidate),
    .countOut   (countOut),
    .frameNum   (frameNum),
    .hitCount   (hitCount),
    .memREN     (memReq.REN)
  );

  dcacheControl control (
    .CLK        (CLK),
    .nRST       (nRST),
    .dirty      (dirty),
    .anyDirty   (anyDirty),
    .dhit       (dpResp.dhit),
    .memWait    (memResp.dWait),
    .memREN     (dpReq.memREN),
    .memWEN     (dpReq.memWEN),
    .halt       (dpReq.halt),
    .cacheREN   (memReq.REN),
    .cacheWEN   (memReq.WEN),
    .flushStep  (flushStep),
    .hitUp      (hitUp),
    .hitDown    (hitDown),
    .countOut   (countOut),
    .blockOff   (blockOff),
    .invalidate (invalidate),
    .flushing   (flushing),
    .flushed    (dpResp.flushed)
  );

  // hits minus misses
  flexCounter #(.BITS($bits(wordT))) hitCounter (
    .CLK       (CLK),
    .nRST      (nRST),
    .countUp   (hitUp),
    .countDown (hitDown),
    .count     (hitCount)
  );

  // flush frame index, only counts up
  flexCounter #(.BITS($bits(frameNumT))) frameCounter (
    .CLK       (CLK),
    .nRST      (nRST),
    .countUp   (flushStep),
    .countDown (1'b0),
    .count     (frameNum)
  );

endmodule

`default_nettype wire

// File: verif/memModel.sv
// Latency memory model
`timescale 1ns/1ps
`default_nettype none

module memModel #(
  parameter int WAIT_CYCLES = 2,
  parameter int DEPTH = 4096
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  cacheTypesPkg::memReqT  memReq,
  output cacheTypesPkg::memRespT memResp
);
  import cpuTypesPkg::*;

  localparam int IDX_BITS = $clog2(DEPTH);

  // word addressed backing store
  wordT words [DEPTH];
  int busyCount;
  logic access;
  logic [IDX_BITS-1:0] wordIdx;

  assign access = memReq.REN || memReq.WEN;
  // drop the byte offset of the address
  assign wordIdx = memReq.addr[IDX_BITS+1:2];

  // wait drops on the last cycle of an access
  assign memResp.dWait = access && (busyCount != WAIT_CYCLES);
  assign memResp.load = words[wordIdx];

  always @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busyCount <= 0;
      // preset pattern is word address times 3
      for (int i = 0; i < DEPTH; i++) begin
        words[i] <= wordT'(i * 3);
      end
    end else if (access) begin
      if (busyCount == WAIT_CYCLES) begin
        // access completes and the next one starts from zero
        busyCount <= 0;
        if (memReq.WEN) begin
          words[wordIdx] <= memReq.store;
        end
      end else begin
        busyCount <= busyCount + 1;
      end
    end else begin
      busyCount <= 0;
    end
  end

endmodule

`default_nettype wire

// File: verif/dcache_asserts.sv
// Cache control checks
`timescale 1ns/1ps
`default_nettype none

module dcacheAsserts (
  input logic                   CLK,
  input logic                   nRST,
  input logic                   cacheREN,
  input logic                   cacheWEN,
  input logic                   memWait,
  input logic                   flushed,
  input cacheTypesPkg::dcStateT state
);

  // tally for the testbench verdict
  int failures = 0;

  // parked cache leaves memory alone
  flushedQuiet: assert property (@(posedge CLK) disable iff (!nRST)
    flushed |-> (!cacheREN && !cacheWEN))
    else begin
      $error("memory request raised while flushed");
      failures++;
    end

  // one direction at a time
  oneDirection: assert property (@(posedge CLK) disable iff (!nRST)
    !(cacheREN && cacheWEN))
    else begin
      $error("memory read and write raised together");
      failures++;
    end

  // busy memory freezes the sequencer
  holdOnWait: assert property (@(posedge CLK) disable iff (!nRST)
    ((cacheREN || cacheWEN) && memWait) |=> $stable(state))
    else begin
      $error("control state moved while memory wait was high");
      failures++;
    end

endmodule

bind dcacheControl dcacheAsserts checks (
  .CLK      (CLK),
  .nRST     (nRST),
  .cacheREN (cacheREN),
  .cacheWEN (cacheWEN),
  .memWait  (memWait),
  .flushed  (flushed),
  .state    (state)
);

`default_nettype wire

// File: verif/dcacheTb.sv
// Data cache testbench
`timescale 1ns/1ps
`default_nettype none

module dcacheTb;
  import cpuTypesPkg::*;
  import cacheTypesPkg::*;

  localparam string TESTS_FILE = "verif/dcache_tests.txt";
  localparam int CYCLES_PER_LINE = 200;
  localparam int MEM_WORDS = 4096;

  logic CLK;
  logic nRST;
  dpReqT dpReq;
  dpRespT dpResp;
  memReqT memReq;
  memRespT memResp;

  // one entry per tests file line
  byte opQ[$];
  addrT addrQ[$];
  wordT dataQ[$];
  wordT expQ[$];
  byte markQ[$];

  int cycles = 0;
  int cycleLimit = 0;
  int requestCount = 0;
  int missCount = 0;
  logic halted = 1'b0;

  dataCacheUnit dut (
    .CLK     (CLK),
    .nRST    (nRST),
    .dpReq   (dpReq),
    .dpResp  (dpResp),
    .memReq  (memReq),
    .memResp (memResp)
  );

  memModel #(.WAIT_CYCLES(2), .DEPTH(MEM_WORDS)) memory (
    .CLK     (CLK),
    .nRST    (nRST),
    .memReq  (memReq),
    .memResp (memResp)
  );

  always #5 CLK = ~CLK;

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped");
  endtask

  // hung run guard
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycleLimit > 0 && cycles >= cycleLimit) begin
      failRun($sformatf("no progress after %0d cycles, run ended", cycles));
    end
  end

  task automatic checkWord(input addrT addr, input wordT got, input wordT exp);
    if (got !== exp) begin
      failRun($sformatf("** Error at %0t: word at %h is %h, expected %h",
                        $time, addr, got, exp));
    end
  endtask

  task automatic checkCount(input wordT got, input wordT exp);
    if (got !== exp) begin
      failRun($sformatf("** Error at %0t: hit counter is %0d, expected %0d",
                        $time, $signed(got), $signed(exp)));
    end
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      failRun($sformatf("** Error at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  function automatic wordT memWord(input addrT addr);
    return memory.words[addr[13:2]];
  endfunction

  task automatic loadTests();
    int fd;
    int n;
    string line;
    byte op;
    byte mark;
    addrT addr;
    wordT data;
    wordT exp;
    fd = $fopen(TESTS_FILE, "r");
    if (fd == 0) begin
      failRun("could not open the tests file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // skip blank and comment lines
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%c %h %h %h %c", op, addr, data, exp, mark);
          if (n != 5) begin
            failRun($sformatf("malformed tests file line: %s", line));
          end else begin
            opQ.push_back(op);
            addrQ.push_back(addr);
            dataQ.push_back(data);
            expQ.push_back(exp);
            markQ.push_back(mark);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // request held until dhit and dropped after the hit edge
  task automatic doRequest(input int i);
    @(posedge CLK);
    #1;
    dpReq.memREN = (opQ[i] == "R");
    dpReq.memWEN = (opQ[i] == "W");
    dpReq.memAddr = addrQ[i];
    dpReq.memStore = dataQ[i];
    @(negedge CLK);
    // a hit answers in the request cycle, a miss does not
    checkFlag(dpResp.dhit, markQ[i] == "h", "dhit on the first request cycle");
    while (!dpResp.dhit) begin
      @(negedge CLK);
    end
    if (opQ[i] == "R") begin
      checkWord(addrQ[i], dpResp.memLoad, expQ[i]);
    end
    @(posedge CLK);
    #1;
    dpReq.memREN = 1'b0;
    dpReq.memWEN = 1'b0;
    requestCount++;
    if (markQ[i] == "m") begin
      missCount++;
    end
  endtask

  task automatic runHalt();
    @(posedge CLK);
    #1;
    dpReq.halt = 1'b1;
    @(negedge CLK);
    while (!dpResp.flushed) begin
      @(negedge CLK);
    end
    // every request ends on one hit cycle and each miss takes one back
    checkCount(memWord(HIT_COUNT_ADDR), wordT'(requestCount - missCount));
    repeat (4) @(negedge CLK);
    checkFlag(dpResp.flushed, 1'b1, "flushed after halt");
    halted = 1'b1;
  endtask

  initial begin
    CLK = 1'b0;
    nRST = 1'b0;
    dpReq = '0;
    void'($urandom(32'h7b40fe90));
    loadTests();
    cycleLimit = CYCLES_PER_LINE * opQ.size();
    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;

    foreach (opQ[i]) begin
      case (opQ[i])
        "R", "W": begin
          // idle gap between requests
          repeat ($urandom_range(0, 3)) @(posedge CLK);
          doRequest(i);
        end
        "C": checkWord(addrQ[i], memWord(addrQ[i]), expQ[i]);
        "H": begin
          if (!halted) begin
            runHalt();
          end
          checkWord(addrQ[i], memWord(addrQ[i]), expQ[i]);
        end
        default: failRun($sformatf("unknown operation %c in the tests file", opQ[i]));
      endcase
    end

    if (dut.control.checks.failures != 0) begin
      failRun("bound assertions on the control unit failed");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: compile.f
logic/cpuTypesPkg.sv
logic/cacheTypesPkg.sv
logic/flexCounter.sv
logic/dcacheControl.sv
logic/dcache.sv
logic/dataCacheUnit.sv
verif/memModel.sv
verif/dcache_asserts.sv
verif/dcacheTb.sv

// File: run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG='*** TEST FAILED ***'

verilator --binary --timing --assert -f compile.f --top-module dcacheTb -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# raise the error limit so bound assertion failures reach the testbench verdict
./obj_dir/simv +verilator+error+limit+100 > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -qF "$FAIL_MSG" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

echo "simulation finished cleanly"
exit 0

// File: verif/dcache_tests.txt
# op addr data expect mark; R read, W write, C memory word before halt, H halt then memory word
# mark h hit, m miss, - none; addr, data and expect in hex
R 00000050 00000000 0000003c m
R 00000054 00000000 0000003f h
R 00000050 00000000 0000003c h
W 00000050 deadbeef 00000000 h
C 00000050 00000000 0000003c -
R 00000050 00000000 deadbeef h
W 00000040 11111111 00000000 m
W 00000084 22222222 00000000 m
R 00000040 00000000 11111111 h
R 000000c0 00000000 00000090 m
C 00000084 00000000 22222222 -
C 00000080 00000000 00000060 -
R 00000040 00000000 11111111 h
R 00000084 00000000 22222222 m
W 000001fc 55aa55aa 00000000 m
R 000001f8 00000000 0000017a h
W 00000054 0badf00d 00000000 h
H 00000050 00000000 deadbeef -
H 00000054 00000000 0badf00d -
H 00000040 00000000 11111111 -
H 00000044 00000000 00000033 -
H 000001f8 00000000 0000017a -
H 000001fc 00000000 55aa55aa -
H 00000080 00000000 00000060 -
H 00000084 00000000 22222222 -
H 000000c0 00000000 00000090 -
